//--- hdl/echo_pkg.sv
`default_nettype none

package echo_pkg;

    // --------------------------------------------------
    // Data path widths
    // --------------------------------------------------
    localparam int adc_data_w  = 10;   // ADC sample bus
    localparam int dac_data_w  = 10;   // DAC gain code
    localparam int env_data_w  = 8;    // Envelope and gain fields of a buffer word
    localparam int topturn_n   = 3;    // Top-turn input pins

    // Envelope buffer word
    // Bits 7:0 envelope mean
    // Bits 15:8 gain code, top bits of the DAC word
    // Bits 18:16 top-turn inputs
    // Upper bits always zero
    localparam int buff_data_w = 24;

    // --------------------------------------------------
    // Acquisition sequencer
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a start pulse
        RUN,    // Streaming one line of samples
        DONE    // One-cycle done pulse
    } acq_state_t;

endpackage

`default_nettype wire

//--- hdl/trig_cond.sv
`default_nettype none

module trig_cond #(
    parameter int DEBOUNCE_DELAY = 2000000  // Stable cycles before level change
) (
    input  wire  sys_clk,
    input  wire  sys_rst,
    input  logic trig_raw,     // Raw pin or button
    output logic trig_pulse    // One cycle per debounced rising edge
);

    localparam int cnt_w = $clog2(DEBOUNCE_DELAY + 1);

    logic             raw_ff;     // Input register
    logic [cnt_w-1:0] stable_cnt; // Cycles the input differs from the level
    logic             deb_level;  // Debounced level
    logic             deb_prev;   // Level one cycle ago

    // --------------------------------------------------
    // Debouncer
    // --------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            raw_ff     <= 1'b0;
            stable_cnt <= '0;
            deb_level  <= 1'b0;
        end else begin
            raw_ff <= trig_raw;
            if (raw_ff == deb_level) begin
                stable_cnt <= '0;                 // No change pending
            end else if (stable_cnt == cnt_w'(DEBOUNCE_DELAY - 1)) begin
                // Held long enough, accept new level
                deb_level  <= raw_ff;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Rising edge detect
    // --------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            deb_prev <= 1'b0;
        end else begin
            deb_prev <= deb_level;
        end
    end

    assign trig_pulse = deb_level & ~deb_prev;  // High only on the first cycle

endmodule

`default_nettype wire

//--- hdl/line_acq.sv
`default_nettype none

module line_acq
    import echo_pkg::*;
#(
    parameter int LINE_WORDS = 16384    // Samples per line
) (
    input  wire                           sys_clk,
    input  wire                           sys_rst,
    input  logic                          acq_start,  // Start pulse
    input  logic [adc_data_w-1:0]         adc_d,      // Raw ADC bus
    output logic                          acq_busy,   // Line in progress
    output logic                          acq_done,   // Pulse after last sample
    output logic                          acq_wen,    // Sample write enable
    output logic [$clog2(LINE_WORDS)-1:0] acq_waddr,  // Sample index in line
    output logic [adc_data_w-1:0]         acq_wdata   // Sample value
);

    localparam int cnt_w = $clog2(LINE_WORDS);

    logic [adc_data_w-1:0] adc_d_ff;   // Registered ADC bus
    acq_state_t            state;
    acq_state_t            state_next;
    logic [cnt_w-1:0]      word_cnt;   // Current sample index
    logic                  last_word;

    // --------------------------------------------------
    // ADC input register
    // --------------------------------------------------
    always_ff @(posedge sys_clk) begin
        adc_d_ff <= adc_d;   // One cycle behind the pins
    end

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    assign last_word = (word_cnt == cnt_w'(LINE_WORDS - 1));

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (acq_start) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (last_word) begin
                    state_next = DONE;   // Line complete
                end
            end
            DONE: begin
                state_next = IDLE;       // Starts here are dropped
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Word counter, cleared when a line starts
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            word_cnt <= '0;
        end else if (state == IDLE) begin
            word_cnt <= '0;
        end else if (state == RUN) begin
            word_cnt <= word_cnt + 1'b1;   // Wraps to zero after last word
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign acq_busy  = (state == RUN);
    assign acq_wen   = (state == RUN);    // One sample per cycle, no stalls
    assign acq_done  = (state == DONE);
    assign acq_waddr = word_cnt;
    assign acq_wdata = adc_d_ff;

endmodule

`default_nettype wire

//--- hdl/env_builder.sv
`default_nettype none

module env_builder
    import echo_pkg::*;
#(
    parameter int LINE_WORDS  = 16384,  // Samples per line
    parameter int BUFF_ADDR_W = 9,      // Envelope buffer address width
    parameter int GAIN_N      = 32      // Gain segments per line
) (
    input  wire                           sys_clk,
    input  wire                           sys_rst,
    input  logic                          acq_start,   // Line start pulse
    input  logic                          acq_wen,     // Sample stream
    input  logic [$clog2(LINE_WORDS)-1:0] acq_waddr,
    input  logic [adc_data_w-1:0]         acq_wdata,
    input  logic [dac_data_w-1:0]         dac_gain,    // Current gain code
    input  logic [topturn_n-1:0]          topturn,     // Top-turn pins
    output logic                          buff_wr,     // Buffer write port
    output logic [BUFF_ADDR_W-1:0]        buff_waddr,
    output logic [buff_data_w-1:0]        buff_wdata
);

    // --------------------------------------------------
    // Derived sizes
    // --------------------------------------------------
    localparam int buff_words  = 2 ** BUFF_ADDR_W;
    localparam int chunk_words = LINE_WORDS / buff_words;   // Samples per envelope word
    localparam int chunk_w     = $clog2(chunk_words);
    localparam int env_shift   = chunk_w + 1;               // Mean plus half scale
    localparam int gain_words  = LINE_WORDS / GAIN_N;       // Samples per gain segment
    localparam int gain_w      = $clog2(gain_words);
    localparam int dev_w       = adc_data_w - 1;            // Deviation from midrange
    localparam int sum_w       = dev_w + chunk_w;           // Holds a full chunk
    localparam int pad_w       = buff_data_w - topturn_n - 2 * env_data_w;

    logic                  fill_en;       // Buffer fill active
    logic                  chunk_start;   // First sample of a chunk
    logic                  gain_start;    // First sample of a gain segment
    logic [dev_w-1:0]      dev;           // Absolute deviation of sample
    logic [sum_w-1:0]      env_sum;
    logic [env_data_w-1:0] env_mean;
    logic [env_data_w-1:0] gain_q;        // Gain of current segment
    logic [topturn_n-1:0]  topturn_q;     // Top-turn at chunk start

    // --------------------------------------------------
    // Fill control
    // --------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            fill_en <= 1'b0;
        end else if (acq_start) begin
            fill_en <= 1'b1;
        end else if (buff_wr && !acq_wen) begin
            fill_en <= 1'b0;   // Last word of the line written
        end
    end

    // Write strobe and address one cycle behind the stream
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            buff_wr    <= 1'b0;
            buff_waddr <= '0;
        end else if (fill_en) begin
            buff_wr    <= acq_wen;
            buff_waddr <= acq_waddr[chunk_w +: BUFF_ADDR_W];   // Chunk index
        end else begin
            buff_wr    <= 1'b0;
            buff_waddr <= '0;
        end
    end

    // --------------------------------------------------
    // Envelope accumulation
    // --------------------------------------------------
    assign chunk_start = (acq_waddr[chunk_w-1:0] == '0);
    assign gain_start  = (acq_waddr[gain_w-1:0] == '0);

    // Distance from midrange, sign bit picks the side
    assign dev = acq_wdata[adc_data_w-1] ? acq_wdata[dev_w-1:0]
                                         : dev_w'(511) - acq_wdata[dev_w-1:0];

    always_ff @(posedge sys_clk) begin
        if (fill_en && acq_wen) begin
            if (chunk_start) begin
                env_sum <= sum_w'(dev);            // New chunk
            end else begin
                env_sum <= env_sum + sum_w'(dev);
            end
        end
    end

    assign env_mean = env_sum[env_shift +: env_data_w];

    // --------------------------------------------------
    // Gain and top-turn sampling
    // --------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (fill_en && acq_wen && gain_start) begin
            gain_q <= dac_gain[dac_data_w-1 -: env_data_w];   // Drop two LSBs
        end
        if (fill_en && acq_wen && chunk_start) begin
            topturn_q <= topturn;
        end
    end

    // Word for the chunk of the previous sample
    assign buff_wdata = {{pad_w{1'b0}}, topturn_q, gain_q, env_mean};

endmodule

`default_nettype wire

//--- hdl/env_buff.sv
`default_nettype none

module env_buff
    import echo_pkg::*;
#(
    parameter int BUFF_ADDR_W = 9    // Buffer depth is two to this power
) (
    input  wire                    sys_clk,
    input  wire                    sys_rst,
    // Write side
    input  logic                   buff_wr,
    input  logic [BUFF_ADDR_W-1:0] buff_waddr,
    input  logic [buff_data_w-1:0] buff_wdata,
    // Read side
    input  logic                   buff_rd,
    input  logic [BUFF_ADDR_W-1:0] buff_raddr,
    output logic [buff_data_w-1:0] buff_rdata,   // Valid one cycle after read
    output logic                   buff_rvalid
);

    logic [buff_data_w-1:0] mem [0:(2**BUFF_ADDR_W)-1];

    // --------------------------------------------------
    // Memory array
    // --------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (buff_wr) begin
            mem[buff_waddr] <= buff_wdata;
        end
        if (buff_rd) begin
            buff_rdata <= mem[buff_raddr];   // Registered read
        end
    end

    // Valid flag tracks the read strobe
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            buff_rvalid <= 1'b0;
        end else begin
            buff_rvalid <= buff_rd;
        end
    end

endmodule

`default_nettype wire

//--- hdl/echo_top.sv
`default_nettype none

module echo_top
    import echo_pkg::*;
#(
    parameter int LINE_WORDS     = 16384,    // Samples per line
    parameter int BUFF_ADDR_W    = 9,        // Envelope buffer address width
    parameter int GAIN_N         = 32,       // Gain segments per line
    parameter int DEBOUNCE_DELAY = 2000000   // Trigger debounce in clock cycles
) (
    input  wire                           sys_clk,
    input  wire                           sys_rst,
    // Trigger sources
    input  logic                          btn_trig,    // Push button
    input  logic                          trig_in,     // External trigger pin
    // Analog front end
    input  logic [adc_data_w-1:0]         adc_d,
    input  logic [dac_data_w-1:0]         dac_gain,
    input  logic [topturn_n-1:0]          topturn,
    // Acquisition status and sample stream
    output logic                          acq_busy,
    output logic                          acq_done,
    output logic                          acq_wen,
    output logic [$clog2(LINE_WORDS)-1:0] acq_waddr,
    output logic [adc_data_w-1:0]         acq_wdata,
    // Envelope buffer read port
    input  logic                          buff_rd,
    input  logic [BUFF_ADDR_W-1:0]        buff_raddr,
    output logic [buff_data_w-1:0]        buff_rdata,
    output logic                          buff_rvalid
);

    logic                   btn_pulse;     // Debounced button edge
    logic                   trig_pulse;    // Debounced trigger pin edge
    logic                   acq_start;
    logic                   buff_wr;
    logic [BUFF_ADDR_W-1:0] buff_waddr;
    logic [buff_data_w-1:0] buff_wdata;

    // --------------------------------------------------
    // Trigger conditioning
    // --------------------------------------------------
    trig_cond #(
        .DEBOUNCE_DELAY (DEBOUNCE_DELAY)
    ) btn_cond_i (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .trig_raw   (btn_trig),
        .trig_pulse (btn_pulse)
    );

    trig_cond #(
        .DEBOUNCE_DELAY (DEBOUNCE_DELAY)
    ) pin_cond_i (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .trig_raw   (trig_in),
        .trig_pulse (trig_pulse)
    );

    assign acq_start = btn_pulse | trig_pulse;   // Either source starts a line

    // --------------------------------------------------
    // Line acquisition
    // --------------------------------------------------
    line_acq #(
        .LINE_WORDS (LINE_WORDS)
    ) line_acq_i (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .acq_start (acq_start),
        .adc_d     (adc_d),
        .acq_busy  (acq_busy),
        .acq_done  (acq_done),
        .acq_wen   (acq_wen),
        .acq_waddr (acq_waddr),
        .acq_wdata (acq_wdata)
    );

    // --------------------------------------------------
    // Envelope path
    // --------------------------------------------------
    env_builder #(
        .LINE_WORDS  (LINE_WORDS),
        .BUFF_ADDR_W (BUFF_ADDR_W),
        .GAIN_N      (GAIN_N)
    ) env_builder_i (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .acq_start  (acq_start),
        .acq_wen    (acq_wen),
        .acq_waddr  (acq_waddr),
        .acq_wdata  (acq_wdata),
        .dac_gain   (dac_gain),
        .topturn    (topturn),
        .buff_wr    (buff_wr),
        .buff_waddr (buff_waddr),
        .buff_wdata (buff_wdata)
    );

    env_buff #(
        .BUFF_ADDR_W (BUFF_ADDR_W)
    ) env_buff_i (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .buff_wr     (buff_wr),
        .buff_waddr  (buff_waddr),
        .buff_wdata  (buff_wdata),
        .buff_rd     (buff_rd),      // Driven from outside
        .buff_raddr  (buff_raddr),
        .buff_rdata  (buff_rdata),
        .buff_rvalid (buff_rvalid)
    );

endmodule

`default_nettype wire

//--- bench/echo_assertions.sv
`default_nettype none

module echo_assertions
    import echo_pkg::*;
#(
    parameter int LINE_WORDS     = 16384,
    parameter int DEBOUNCE_DELAY = 2000000
) (
    input wire                          sys_clk,
    input wire                          sys_rst,
    input logic                         btn_trig,
    input logic                         trig_in,
    input logic [adc_data_w-1:0]        adc_d,
    input logic                         acq_start,   // Internal OR of both trigger pulses
    input logic                         acq_busy,
    input logic                         acq_done,
    input logic                         acq_wen,
    input logic [$clog2(LINE_WORDS)-1:0] acq_waddr,
    input logic [adc_data_w-1:0]        acq_wdata,
    input logic                         buff_rd,
    input logic                         buff_rvalid
);

    localparam int addr_w = $clog2(LINE_WORDS);

    int   fail_cnt = 0;   // Read back by the testbench
    int   btn_run;        // Length of latest high run on the button
    int   pin_run;        // Same for the trigger pin
    int   wen_cnt;        // Consecutive write cycles so far
    logic btn_q;
    logic pin_q;

    // --------------------------------------------------
    // Helper counters
    // --------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            btn_run <= 0;
            pin_run <= 0;
            btn_q   <= 1'b0;
            pin_q   <= 1'b0;
            wen_cnt <= 0;
        end else begin
            btn_q <= btn_trig;
            pin_q <= trig_in;
            if (btn_trig) begin
                btn_run <= btn_q ? btn_run + 1 : 1;   // Held while low
            end
            if (trig_in) begin
                pin_run <= pin_q ? pin_run + 1 : 1;
            end
            wen_cnt <= acq_wen ? wen_cnt + 1 : 0;
        end
    end

    // --------------------------------------------------
    // Trigger and idle behavior
    // --------------------------------------------------
    start_needs_stable_input: assert property (@(posedge sys_clk) disable iff (sys_rst)
        acq_start |-> (btn_run >= DEBOUNCE_DELAY || pin_run >= DEBOUNCE_DELAY))
        else begin $error("start without a stable trigger input"); fail_cnt++; end

    busy_needs_start: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $rose(acq_busy) |-> $past(acq_start))
        else begin $error("acq_busy rose without a start"); fail_cnt++; end

    wen_needs_start: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $rose(acq_wen) |-> $past(acq_start))
        else begin $error("acq_wen rose without a start"); fail_cnt++; end

    rvalid_after_rd: assert property (@(posedge sys_clk) disable iff (sys_rst)
        buff_rvalid |-> $past(buff_rd))
        else begin $error("buff_rvalid without buff_rd"); fail_cnt++; end

    // --------------------------------------------------
    // Line framing
    // --------------------------------------------------
    wen_inside_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
        acq_wen |-> acq_busy)
        else begin $error("acq_wen outside acq_busy"); fail_cnt++; end

    done_after_full_line: assert property (@(posedge sys_clk) disable iff (sys_rst)
        acq_done |-> (wen_cnt == LINE_WORDS && !acq_busy && !acq_wen))
        else begin $error("acq_done not after a full line"); fail_cnt++; end

    wen_end_gives_done: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $fell(acq_wen) |-> acq_done)
        else begin $error("write stream ended without acq_done"); fail_cnt++; end

    done_single_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst)
        acq_done |=> !acq_done)
        else begin $error("acq_done longer than one cycle"); fail_cnt++; end

    // --------------------------------------------------
    // Sample stream contents
    // --------------------------------------------------
    addr_starts_zero: assert property (@(posedge sys_clk) disable iff (sys_rst)
        $rose(acq_wen) |-> acq_waddr == '0)
        else begin $error("acq_waddr not zero at line start"); fail_cnt++; end

    addr_steps_one: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (acq_wen && $past(acq_wen)) |-> (acq_waddr - $past(acq_waddr)) == addr_w'(1))
        else begin $error("acq_waddr did not step by one"); fail_cnt++; end

    wdata_is_past_adc: assert property (@(posedge sys_clk) disable iff (sys_rst)
        acq_wen |-> acq_wdata == $past(adc_d))
        else begin $error("acq_wdata differs from delayed adc_d"); fail_cnt++; end

endmodule

bind echo_top echo_assertions #(
    .LINE_WORDS     (LINE_WORDS),
    .DEBOUNCE_DELAY (DEBOUNCE_DELAY)
) echo_assertions_i (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .btn_trig    (btn_trig),
    .trig_in     (trig_in),
    .adc_d       (adc_d),
    .acq_start   (acq_start),
    .acq_busy    (acq_busy),
    .acq_done    (acq_done),
    .acq_wen     (acq_wen),
    .acq_waddr   (acq_waddr),
    .acq_wdata   (acq_wdata),
    .buff_rd     (buff_rd),
    .buff_rvalid (buff_rvalid)
);

`default_nettype wire

//--- bench/tb_echo_top.sv
`default_nettype none

module tb_echo_top
    import echo_pkg::*;
();

    localparam int line_words     = 1024;
    localparam int buff_addr_w    = 5;
    localparam int gain_n         = 32;
    localparam int debounce_delay = 20;
    localparam int buff_words     = 2 ** buff_addr_w;
    localparam int chunk_words    = line_words / buff_words;
    localparam int env_shift      = $clog2(chunk_words) + 1;
    // Four lines, four trigger events, two readbacks, plus margin
    localparam int timeout_cycles = 4 * line_words + 4 * 4 * debounce_delay
                                    + 2 * 3 * buff_words + 2000;

    logic                          sys_clk;
    logic                          sys_rst;
    logic                          btn_trig;
    logic                          trig_in;
    logic [adc_data_w-1:0]         adc_d = '0;
    logic [dac_data_w-1:0]         dac_gain;
    logic [topturn_n-1:0]          topturn;
    logic                          acq_busy;
    logic                          acq_done;
    logic                          acq_wen;
    logic [$clog2(line_words)-1:0] acq_waddr;
    logic [adc_data_w-1:0]         acq_wdata;
    logic                          buff_rd;
    logic [buff_addr_w-1:0]        buff_raddr;
    logic [buff_data_w-1:0]        buff_rdata;
    logic                          buff_rvalid;

    logic [31:0]           lfsr_state = 32'h3388;
    logic [adc_data_w-1:0] adc_prev;                    // What the ADC register holds
    logic [adc_data_w-1:0] line_samples [0:line_words-1];
    int                    sample_idx = 0;              // Position within the current line
    int                    err_cnt = 0;

    echo_top #(
        .LINE_WORDS     (line_words),
        .BUFF_ADDR_W    (buff_addr_w),
        .GAIN_N         (gain_n),
        .DEBOUNCE_DELAY (debounce_delay)
    ) echo_top_i (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .btn_trig    (btn_trig),
        .trig_in     (trig_in),
        .adc_d       (adc_d),
        .dac_gain    (dac_gain),
        .topturn     (topturn),
        .acq_busy    (acq_busy),
        .acq_done    (acq_done),
        .acq_wen     (acq_wen),
        .acq_waddr   (acq_waddr),
        .acq_wdata   (acq_wdata),
        .buff_rd     (buff_rd),
        .buff_raddr  (buff_raddr),
        .buff_rdata  (buff_rdata),
        .buff_rvalid (buff_rvalid)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA3000000 : lfsr_state >> 1;
        end
        return r;
    endfunction

    // --------------------------------------------------
    // ADC stimulus and sample record
    // --------------------------------------------------
    always @(posedge sys_clk) begin
        adc_d    <= adc_data_w'(rand_bits(adc_data_w));
        adc_prev <= adc_d;
    end

    always @(negedge sys_clk) begin
        if (acq_wen) begin
            line_samples[sample_idx] = adc_prev;   // Stable mid-cycle
            sample_idx++;
        end else begin
            sample_idx = 0;                        // Next line starts at zero
        end
    end

    // Hold one trigger source high for a number of cycles
    task automatic press_trigger(input bit use_pin, input int cycles);
        @(posedge sys_clk);
        if (use_pin) trig_in <= 1'b1;
        else btn_trig <= 1'b1;
        repeat (cycles) @(posedge sys_clk);
        trig_in  <= 1'b0;
        btn_trig <= 1'b0;
    endtask

    task automatic wait_busy(input int limit);
        int n;
        n = 0;
        @(negedge sys_clk);
        while (!acq_busy && n < limit) begin
            @(negedge sys_clk);
            n++;
        end
        if (!acq_busy) begin
            $display("acq_busy never rose after a clean trigger at t=%0t", $time);
            err_cnt++;
        end
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        @(negedge sys_clk);
        while (!acq_done && n < limit) begin
            @(negedge sys_clk);
            n++;
        end
        if (!acq_done) begin
            $display("acq_done never came at t=%0t", $time);
            err_cnt++;
        end
    endtask

    // Line must stay idle for a while
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            if (acq_busy || acq_wen) begin
                $display("a line started without a valid trigger at t=%0t", $time);
                err_cnt++;
            end
        end
    endtask

    // --------------------------------------------------
    // Buffer readback against the envelope rule
    // --------------------------------------------------
    task automatic read_check();
        int                     sum;
        logic [adc_data_w-1:0]  s;
        logic [buff_data_w-1:0] exp;
        for (int a = 0; a < buff_words; a++) begin
            sum = 0;
            for (int k = 0; k < chunk_words; k++) begin
                s = line_samples[a * chunk_words + k];
                sum += s[9] ? int'(s[8:0]) : 511 - int'(s[8:0]);   // Distance from midrange
            end
            exp = {5'b0, topturn, dac_gain[9:2], env_data_w'(sum >> env_shift)};
            @(posedge sys_clk);
            buff_rd    <= 1'b1;
            buff_raddr <= buff_addr_w'(a);
            @(posedge sys_clk);
            buff_rd <= 1'b0;
            @(negedge sys_clk);
            if (buff_rvalid !== 1'b1) begin
                $display("error t=%0t buff_rvalid: got %b, expected 1", $time, buff_rvalid);
                err_cnt++;
            end
            if (buff_rdata !== exp) begin
                $display("error t=%0t buff_rdata[%0d]: got %h, expected %h",
                         $time, a, buff_rdata, exp);
                err_cnt++;
            end
        end
    endtask

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge sys_clk);
        $display("timeout after %0d cycles, the run did not finish", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        sys_rst    = 1'b1;
        btn_trig   = 1'b0;
        trig_in    = 1'b0;
        dac_gain   = 10'h2c7;
        topturn    = 3'b101;
        buff_rd    = 1'b0;
        buff_raddr = '0;
        repeat (2) @(posedge sys_clk);
        sys_rst <= 1'b0;
        repeat (5) @(posedge sys_clk);

        press_trigger(1'b0, 5);                     // Glitch, too short
        check_idle(4 * debounce_delay);

        press_trigger(1'b0, 2 * debounce_delay);    // Clean press
        wait_busy(4 * debounce_delay);
        press_trigger(1'b1, 2 * debounce_delay);    // Lands mid line
        wait_done(2 * line_words);
        repeat (4) @(posedge sys_clk);
        read_check();
        check_idle(4 * debounce_delay);             // No second line

        @(posedge sys_clk);
        dac_gain <= 10'h13a;
        topturn  <= 3'b010;
        press_trigger(1'b1, 2 * debounce_delay);    // Second source
        wait_busy(4 * debounce_delay);
        wait_done(2 * line_words);
        repeat (4) @(posedge sys_clk);
        read_check();

        $display("checks failed %0d, assertions failed %0d",
                 err_cnt, echo_top_i.echo_assertions_i.fail_cnt);
        if (err_cnt == 0 && echo_top_i.echo_assertions_i.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/echo_pkg.sv
hdl/trig_cond.sv
hdl/line_acq.sv
hdl/env_builder.sv
hdl/env_buff.sv
hdl/echo_top.sv
bench/echo_assertions.sv
bench/tb_echo_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_echo_top
FILELIST  = tb.f
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
